// File: rank_pkg.sv
// Shared definitions for the matrix rank engine
// Element and size widths, the operand bundle fed to the modular
// arithmetic units, the engine FSM encoding and the element store type

package rank_pkg;

  ////////////////////////////////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////////////////////////////////

  // Element and modulus width
  localparam int DATA_SIZE = 16;

  // Largest row or column count
  localparam int MAX_DIM = 4;

  // Size, index and rank width, holds 0 to MAX_DIM
  localparam int DIM_SIZE = 3;

  ////////////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////////////

  // Operand bundle for the adder and the multiplier
  typedef struct packed {
    logic [DATA_SIZE-1:0] modulo;
    logic [DATA_SIZE-1:0] a;
    logic [DATA_SIZE-1:0] b;
  } mod_operands_t;

  // Engine FSM states
  typedef enum logic [3:0] {
    ST_IDLE,
    ST_LOAD,
    ST_PIVOT,
    ST_SWAP,
    ST_FACTOR,
    ST_PROD1,
    ST_PROD2,
    ST_SUB,
    ST_STREAM,
    ST_DONE
  } rank_state_t;

  // Element store, indexed [row][column]
  typedef logic [MAX_DIM-1:0][MAX_DIM-1:0][DATA_SIZE-1:0] matrix_t;

endpackage

// File: mod_adder.sv
// Modular adder and subtractor
// Forms a + b or a - b with one spare bit and folds the result back
// into [0, modulo). Result is registered, READY one cycle after START

`timescale 1ns/100ps

module mod_adder
  import rank_pkg::*;
(
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 START,
  input  logic                 OPERATION,
  input  mod_operands_t        OPERANDS,
  output logic                 READY,
  output logic [DATA_SIZE-1:0] DATA_OUT
);

  // Raw and corrected results, one bit wider than an element
  logic [DATA_SIZE:0] sum_raw;
  logic [DATA_SIZE:0] sum_fix;
  logic [DATA_SIZE:0] diff_raw;
  logic [DATA_SIZE:0] diff_fix;

  // Add path, subtract modulo once on overflow
  assign sum_raw = {1'b0, OPERANDS.a} + {1'b0, OPERANDS.b};
  assign sum_fix = (sum_raw >= {1'b0, OPERANDS.modulo}) ?
                   sum_raw - {1'b0, OPERANDS.modulo} : sum_raw;

  // Subtract path, top bit set means borrow
  assign diff_raw = {1'b0, OPERANDS.a} - {1'b0, OPERANDS.b};
  assign diff_fix = diff_raw[DATA_SIZE] ?
                    diff_raw + {1'b0, OPERANDS.modulo} : diff_raw;

  // Done strobe
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      READY <= 1'b0;
    end else begin
      READY <= START;
    end
  end

  // Result register, 0 selects add
  always_ff @(posedge CLK) begin
    if (START) begin
      DATA_OUT <= OPERATION ? diff_fix[DATA_SIZE-1:0] : sum_fix[DATA_SIZE-1:0];
    end
  end

  // Caller must hand in reduced operands
  assert property (@(posedge CLK) disable iff (RST)
    START |-> (OPERANDS.a < OPERANDS.modulo) && (OPERANDS.b < OPERANDS.modulo));

endmodule

// File: mod_multiplier.sv
// Interleaved modular multiplier
// Scans operand b from the top bit down, one bit per cycle. Each step
// doubles the accumulator mod m and adds a mod m when the bit is set.
// READY pulses DATA_SIZE + 1 cycles after START

`timescale 1ns/100ps

module mod_multiplier
  import rank_pkg::*;
(
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 START,
  input  mod_operands_t        OPERANDS,
  output logic                 READY,
  output logic [DATA_SIZE-1:0] DATA_OUT
);

  ////////////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////////////

  // Latched operands
  logic [DATA_SIZE-1:0] modulo;
  logic [DATA_SIZE-1:0] multiplicand;
  logic [DATA_SIZE-1:0] multiplier;

  // Step control
  logic                           busy;
  logic [$clog2(DATA_SIZE+1)-1:0] count;

  // One step of the accumulator, with a spare bit
  logic [DATA_SIZE:0] doubled;
  logic [DATA_SIZE:0] doubled_red;
  logic [DATA_SIZE:0] added;
  logic [DATA_SIZE:0] added_red;

  ////////////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////////////

  // Double, then fold once since acc < m
  assign doubled     = {DATA_OUT, 1'b0};
  assign doubled_red = (doubled >= {1'b0, modulo}) ? doubled - {1'b0, modulo} : doubled;

  // Add a when the current top bit of b is set
  assign added     = doubled_red + (multiplier[DATA_SIZE-1] ? {1'b0, multiplicand} : '0);
  assign added_red = (added >= {1'b0, modulo}) ? added - {1'b0, modulo} : added;

  // Operand latch and accumulator, which is also the result
  always_ff @(posedge CLK) begin
    if (START) begin
      modulo       <= OPERANDS.modulo;
      multiplicand <= OPERANDS.a;
      multiplier   <= OPERANDS.b;
      DATA_OUT     <= '0;
    end else if (busy) begin
      DATA_OUT   <= added_red[DATA_SIZE-1:0];
      // Next bit of b moves to the top
      multiplier <= multiplier << 1;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy  <= 1'b0;
      count <= '0;
      READY <= 1'b0;
    end else begin
      READY <= 1'b0;
      if (START) begin
        busy  <= 1'b1;
        count <= ($bits(count))'(DATA_SIZE);
      end else if (busy) begin
        count <= count - 1'b1;
        // Last bit of b processed on this edge
        if (count == 1) begin
          busy  <= 1'b0;
          READY <= 1'b1;
        end
      end
    end
  end

  // Engine waits for READY before issuing the next product
  assert property (@(posedge CLK) disable iff (RST) START |-> !busy);

endmodule

// File: matrix_rank.sv
// Matrix rank engine over the integers modulo a prime
// Loads up to a 4x4 matrix row by row, reduces it to row-echelon form
// by fraction-free elimination, streams the reduced matrix back out
// and reports the rank. Uses one modular multiplier and one modular
// subtractor, so no modular inverse is needed

`timescale 1ns/100ps

module matrix_rank
  import rank_pkg::*;
(
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 START,
  input  logic [DATA_SIZE-1:0] MODULO_IN,
  input  logic [DIM_SIZE-1:0]  SIZE_I_IN,
  input  logic [DIM_SIZE-1:0]  SIZE_J_IN,
  input  logic [DATA_SIZE-1:0] DATA_IN,
  input  logic                 DATA_IN_I_ENABLE,
  input  logic                 DATA_IN_J_ENABLE,
  output logic                 READY,
  output logic [DATA_SIZE-1:0] DATA_OUT,
  output logic                 DATA_OUT_I_ENABLE,
  output logic                 DATA_OUT_J_ENABLE
);

  ////////////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////////////

  rank_state_t state;

  // Request, captured on START
  logic [DATA_SIZE-1:0] modulo;
  logic [DIM_SIZE-1:0]  size_i;
  logic [DIM_SIZE-1:0]  size_j;
  matrix_t              mat;

  // Load and stream position, column also walks the row update
  logic [DIM_SIZE-1:0] i;
  logic [DIM_SIZE-1:0] j;
  // Current rank, pivot column, search row, eliminated row
  logic [DIM_SIZE-1:0] r;
  logic [DIM_SIZE-1:0] c;
  logic [DIM_SIZE-1:0] p;
  logic [DIM_SIZE-1:0] k;

  // Latched a[k][c] and first product
  logic [DATA_SIZE-1:0] factor;
  logic [DATA_SIZE-1:0] prod;

  // Arithmetic unit links
  mod_operands_t        mul_ops;
  mod_operands_t        add_ops;
  logic                 mul_start;
  logic                 add_start;
  logic                 mul_ready;
  logic                 add_ready;
  logic [DATA_SIZE-1:0] mul_out;
  logic [DATA_SIZE-1:0] add_out;

  // Helpers
  logic [DIM_SIZE-1:0]  ld_i;
  logic [DIM_SIZE-1:0]  ld_j;
  logic [DIM_SIZE-1:0]  j_next;
  logic [DIM_SIZE-1:0]  last_row;
  logic [DIM_SIZE-1:0]  last_col;
  logic [DATA_SIZE-1:0] pivot_elem;
  logic [DATA_SIZE-1:0] row_elem;
  logic [DATA_SIZE-1:0] search_elem;

  // Array position from a size-wide index
  function automatic logic [$clog2(MAX_DIM)-1:0] idx(input logic [DIM_SIZE-1:0] v);
    return v[$clog2(MAX_DIM)-1:0];
  endfunction

  // Row index starts at all ones, so the first I enable wraps it to 0
  assign ld_i = DATA_IN_I_ENABLE ? i + DIM_SIZE'(1) : i;
  assign ld_j = DATA_IN_I_ENABLE ? '0 : j;

  assign j_next   = j + DIM_SIZE'(1);
  assign last_row = size_i - DIM_SIZE'(1);
  assign last_col = size_j - DIM_SIZE'(1);

  // Pivot a[r][c], candidate a[k][c], search a[p][c]
  assign pivot_elem  = mat[idx(r)][idx(c)];
  assign row_elem    = mat[idx(k)][idx(c)];
  assign search_elem = mat[idx(p)][idx(c)];

  ////////////////////////////////////////////////////////////////////
  // Element store and operand registers
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    case (state)
      ST_IDLE: begin
        if (START) begin
          modulo <= MODULO_IN;
        end
      end
      ST_LOAD: begin
        if (DATA_IN_J_ENABLE) begin
          mat[idx(ld_i)][idx(ld_j)] <= DATA_IN;
        end
      end
      // Swap rows p and r, no-op when equal
      ST_SWAP: begin
        mat[idx(p)] <= mat[idx(r)];
        mat[idx(r)] <= mat[idx(p)];
      end
      // First product a[r][c] * a[k][0]
      ST_FACTOR: begin
        if (k != size_i && row_elem != '0) begin
          factor  <= row_elem;
          mul_ops <= '{modulo, pivot_elem, mat[idx(k)][0]};
        end
      end
      // Second product f * a[r][j]
      ST_PROD1: begin
        if (mul_ready) begin
          prod    <= mul_out;
          mul_ops <= '{modulo, factor, mat[idx(r)][idx(j)]};
        end
      end
      ST_PROD2: begin
        if (mul_ready) begin
          add_ops <= '{modulo, prod, mul_out};
        end
      end
      // Write back, then queue the next column
      ST_SUB: begin
        if (add_ready) begin
          mat[idx(k)][idx(j)] <= add_out;
          if (j != last_col) begin
            mul_ops <= '{modulo, pivot_elem, mat[idx(k)][idx(j_next)]};
          end
        end
      end
      default: begin
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state             <= ST_IDLE;
      size_i            <= '0;
      size_j            <= '0;
      i                 <= '0;
      j                 <= '0;
      r                 <= '0;
      c                 <= '0;
      p                 <= '0;
      k                 <= '0;
      mul_start         <= 1'b0;
      add_start         <= 1'b0;
      READY             <= 1'b0;
      DATA_OUT          <= '0;
      DATA_OUT_I_ENABLE <= 1'b0;
      DATA_OUT_J_ENABLE <= 1'b0;
    end else begin
      // Pulses default low
      mul_start         <= 1'b0;
      add_start         <= 1'b0;
      READY             <= 1'b0;
      DATA_OUT_I_ENABLE <= 1'b0;
      DATA_OUT_J_ENABLE <= 1'b0;

      case (state)
        ST_IDLE: begin
          if (START) begin
            size_i <= SIZE_I_IN;
            size_j <= SIZE_J_IN;
            i      <= '1;
            j      <= '0;
            r      <= '0;
            c      <= '0;
            p      <= '0;
            state  <= ST_LOAD;
          end
        end

        ST_LOAD: begin
          if (DATA_IN_J_ENABLE) begin
            i <= ld_i;
            j <= ld_j + DIM_SIZE'(1);
            if (ld_i == last_row && ld_j == last_col) begin
              state <= ST_PIVOT;
            end
          end
        end

        // One candidate row per cycle
        ST_PIVOT: begin
          if (c == size_j || r == size_i) begin
            i     <= '0;
            j     <= '0;
            state <= ST_STREAM;
          end else if (search_elem != '0) begin
            state <= ST_SWAP;
          end else if (p == last_row) begin
            // No pivot in this column
            c <= c + DIM_SIZE'(1);
            p <= r;
          end else begin
            p <= p + DIM_SIZE'(1);
          end
        end

        ST_SWAP: begin
          k     <= r + DIM_SIZE'(1);
          state <= ST_FACTOR;
        end

        ST_FACTOR: begin
          if (k == size_i) begin
            // All rows below cleared, next pivot
            r     <= r + DIM_SIZE'(1);
            c     <= c + DIM_SIZE'(1);
            p     <= r + DIM_SIZE'(1);
            state <= ST_PIVOT;
          end else if (row_elem != '0) begin
            j         <= '0;
            mul_start <= 1'b1;
            state     <= ST_PROD1;
          end else begin
            // Already zero in this column
            k <= k + DIM_SIZE'(1);
          end
        end

        ST_PROD1: begin
          if (mul_ready) begin
            mul_start <= 1'b1;
            state     <= ST_PROD2;
          end
        end

        ST_PROD2: begin
          if (mul_ready) begin
            add_start <= 1'b1;
            state     <= ST_SUB;
          end
        end

        ST_SUB: begin
          if (add_ready) begin
            if (j == last_col) begin
              k     <= k + DIM_SIZE'(1);
              state <= ST_FACTOR;
            end else begin
              j         <= j_next;
              mul_start <= 1'b1;
              state     <= ST_PROD1;
            end
          end
        end

        // Row-major, one element per cycle
        ST_STREAM: begin
          DATA_OUT          <= mat[idx(i)][idx(j)];
          DATA_OUT_J_ENABLE <= 1'b1;
          DATA_OUT_I_ENABLE <= (j == '0);
          if (j == last_col) begin
            j <= '0;
            if (i == last_row) begin
              state <= ST_DONE;
            end else begin
              i <= i + DIM_SIZE'(1);
            end
          end else begin
            j <= j_next;
          end
        end

        // Rank reported with READY
        ST_DONE: begin
          READY    <= 1'b1;
          DATA_OUT <= {{(DATA_SIZE-DIM_SIZE){1'b0}}, r};
          state    <= ST_IDLE;
        end

        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Arithmetic units
  ////////////////////////////////////////////////////////////////////

  // Always subtracts, a[r][c]*a[k][j] - f*a[r][j]
  mod_adder u_adder (
    .CLK       (CLK),
    .RST       (RST),
    .START     (add_start),
    .OPERATION (1'b1),
    .OPERANDS  (add_ops),
    .READY     (add_ready),
    .DATA_OUT  (add_out)
  );

  mod_multiplier u_multiplier (
    .CLK      (CLK),
    .RST      (RST),
    .START    (mul_start),
    .OPERANDS (mul_ops),
    .READY    (mul_ready),
    .DATA_OUT (mul_out)
  );

  // Sizes taken on START stay within the store
  assert property (@(posedge CLK) disable iff (RST)
    (state == ST_IDLE && START) |=>
      (size_i != '0 && size_i <= MAX_DIM && size_j != '0 && size_j <= MAX_DIM));

  // End marker is a single pulse
  assert property (@(posedge CLK) disable iff (RST) READY |=> !READY);

endmodule

// File: tb_matrix_rank.sv
// Testbench for the matrix rank engine
// Loads fixed and xorshift random matrices, checks every streamed
// element and the reported rank against a reference elimination

`timescale 1ns/100ps

module tb_matrix_rank
  import rank_pkg::*;
();

  // About 40 requests at no more than 3000 cycles each plus margin
  localparam int CYCLE_LIMIT = 200000;

  logic                 CLK;
  logic                 RST;
  logic                 START;
  logic [DATA_SIZE-1:0] MODULO_IN;
  logic [DIM_SIZE-1:0]  SIZE_I_IN;
  logic [DIM_SIZE-1:0]  SIZE_J_IN;
  logic [DATA_SIZE-1:0] DATA_IN;
  logic                 DATA_IN_I_ENABLE;
  logic                 DATA_IN_J_ENABLE;
  logic                 READY;
  logic [DATA_SIZE-1:0] DATA_OUT;
  logic                 DATA_OUT_I_ENABLE;
  logic                 DATA_OUT_J_ENABLE;

  // Expected results of the request in flight
  matrix_t              exp_mat;
  int                   exp_rank;
  int                   exp_rows = 0;
  int                   exp_cols = 1;
  logic [DATA_SIZE-1:0] exp_val;
  int                   out_count;
  bit                   got_ready;
  // Previous cycle carried a streamed element
  bit                   in_stream = 1'b0;

  // Bookkeeping
  int          errors = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          cycles = 0;
  logic [31:0] rng;

  matrix_rank dut (
    .CLK               (CLK),
    .RST               (RST),
    .START             (START),
    .MODULO_IN         (MODULO_IN),
    .SIZE_I_IN         (SIZE_I_IN),
    .SIZE_J_IN         (SIZE_J_IN),
    .DATA_IN           (DATA_IN),
    .DATA_IN_I_ENABLE  (DATA_IN_I_ENABLE),
    .DATA_IN_J_ENABLE  (DATA_IN_J_ENABLE),
    .READY             (READY),
    .DATA_OUT          (DATA_OUT),
    .DATA_OUT_I_ENABLE (DATA_OUT_I_ENABLE),
    .DATA_OUT_J_ENABLE (DATA_OUT_J_ENABLE)
  );

  ////////////////////////////////////////////////////////////////////
  // Clock and run limit
  ////////////////////////////////////////////////////////////////////

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  initial begin
    while (cycles < CYCLE_LIMIT) begin
      @(posedge CLK);
      cycles++;
    end
    $display("Timeout after %0d cycles, the engine never finished", CYCLE_LIMIT);
    $display("Finished with errors");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////////////

  // 32-bit xorshift step
  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic rand_below(input int bound, output int v);
    rng = xorshift(rng);
    v = int'(rng % 32'(bound));
  endtask

  // Unused rows and columns stay zero
  task automatic random_matrix(output matrix_t m, input int rows, input int cols,
                               input int modv);
    int v;
    m = '0;
    for (int i = 0; i < rows; i++) begin
      for (int j = 0; j < cols; j++) begin
        rand_below(modv, v);
        m[i][j] = DATA_SIZE'(v);
      end
    end
  endtask

  // Fraction-free row echelon form and its rank
  function automatic matrix_t echelon_ref(input matrix_t m_in, input int rows,
                                          input int cols, input int modv,
                                          output int rank);
    matrix_t                             a;
    logic [MAX_DIM-1:0][DATA_SIZE-1:0]   row_tmp;
    longint                              piv;
    longint                              f;
    longint                              v;
    int                                  r;
    int                                  p;
    a = m_in;
    r = 0;
    for (int c = 0; c < cols; c++) begin
      if (r < rows) begin
        p = r;
        while (p < rows && a[p][c] == '0) p++;
        if (p < rows) begin
          row_tmp = a[p];
          a[p]    = a[r];
          a[r]    = row_tmp;
          piv     = longint'(a[r][c]);
          for (int k = r + 1; k < rows; k++) begin
            if (a[k][c] != '0) begin
              // Factor taken before the row changes
              f = longint'(a[k][c]);
              for (int j = 0; j < cols; j++) begin
                v = (piv * longint'(a[k][j]) - f * longint'(a[r][j])) % longint'(modv);
                if (v < 0) v = v + longint'(modv);
                a[k][j] = DATA_SIZE'(v);
              end
            end
          end
          r++;
        end
      end
    end
    rank = r;
    return a;
  endfunction

  // Runs one request with optional gaps and an ignored START while busy
  task automatic run_request(input string name, input matrix_t m, input int rows,
                             input int cols, input int modv, input int max_gap,
                             input bit busy_start);
    int errors_before;
    int gap;
    int rank;
    errors_before = errors;
    exp_mat   = echelon_ref(m, rows, cols, modv, rank);
    exp_rank  = rank;
    exp_rows  = rows;
    exp_cols  = cols;
    out_count = 0;
    got_ready = 1'b0;
    @(posedge CLK);
    #1;
    START     = 1'b1;
    MODULO_IN = DATA_SIZE'(modv);
    SIZE_I_IN = DIM_SIZE'(rows);
    SIZE_J_IN = DIM_SIZE'(cols);
    @(posedge CLK);
    #1;
    START = 1'b0;
    for (int i = 0; i < rows; i++) begin
      for (int j = 0; j < cols; j++) begin
        DATA_IN          = m[i][j];
        DATA_IN_I_ENABLE = (j == 0);
        DATA_IN_J_ENABLE = 1'b1;
        @(posedge CLK);
        #1;
        DATA_IN_I_ENABLE = 1'b0;
        DATA_IN_J_ENABLE = 1'b0;
        rand_below(max_gap + 1, gap);
        repeat (gap) begin
          @(posedge CLK);
          #1;
        end
      end
    end
    if (busy_start) begin
      // Engine must ignore this modulus and these sizes
      repeat (3) @(posedge CLK);
      #1;
      START     = 1'b1;
      MODULO_IN = DATA_SIZE'(5);
      SIZE_I_IN = DIM_SIZE'(1);
      SIZE_J_IN = DIM_SIZE'(1);
      @(posedge CLK);
      #1;
      START     = 1'b0;
      MODULO_IN = DATA_SIZE'(modv);
    end
    while (!got_ready) @(posedge CLK);
    tests_run++;
    if (errors == errors_before) begin
      $display("%s: pass, rank %0d", name, exp_rank);
    end else begin
      tests_failed++;
      $display("%s: FAIL with %0d errors", name, errors - errors_before);
    end
  endtask

  ////////////////////////////////////////////////////////////////////
  // Compare process
  ////////////////////////////////////////////////////////////////////

  // Registered outputs settle well before the falling edge
  always @(negedge CLK) begin
    if (!RST) begin
      if (DATA_OUT_J_ENABLE) begin
        if (out_count < exp_rows * exp_cols) begin
          exp_val = exp_mat[out_count / exp_cols][out_count % exp_cols];
          if (DATA_OUT !== exp_val) begin
            $display("ERROR %0t: DATA_OUT expected %0d, got %0d", $time, exp_val, DATA_OUT);
            errors++;
          end
          if (DATA_OUT_I_ENABLE !== 1'((out_count % exp_cols) == 0)) begin
            $display("ERROR %0t: DATA_OUT_I_ENABLE expected %0b, got %0b", $time,
                     (out_count % exp_cols) == 0, DATA_OUT_I_ENABLE);
            errors++;
          end
        end
        out_count++;
      end else if (in_stream && out_count != exp_rows * exp_cols) begin
        // Elements come on back-to-back cycles
        $display("Stream stopped after %0d of %0d elements",
                 out_count, exp_rows * exp_cols);
        errors++;
      end
      if (READY) begin
        if (!in_stream) begin
          $display("READY did not come on the cycle after the last element");
          errors++;
        end
        if (out_count != exp_rows * exp_cols) begin
          $display("Stream held %0d elements where %0d were expected",
                   out_count, exp_rows * exp_cols);
          errors++;
        end
        if (DATA_OUT !== DATA_SIZE'(exp_rank)) begin
          $display("ERROR %0t: DATA_OUT (rank) expected %0d, got %0d", $time,
                   exp_rank, DATA_OUT);
          errors++;
        end
        got_ready = 1'b1;
      end
      in_stream = DATA_OUT_J_ENABLE;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////

  initial begin
    matrix_t m;
    int      errors_before;
    RST              = 1'b1;
    START            = 1'b0;
    MODULO_IN        = '0;
    SIZE_I_IN        = '0;
    SIZE_J_IN        = '0;
    DATA_IN          = '0;
    DATA_IN_I_ENABLE = 1'b0;
    DATA_IN_J_ENABLE = 1'b0;
    rng              = 32'hd8321ccb;
    repeat (8) @(posedge CLK);
    #1;
    RST = 1'b0;

    // Idle outputs before any request
    @(negedge CLK);
    errors_before = errors;
    if (READY !== 1'b0) begin
      $display("ERROR %0t: READY expected 0, got %0b", $time, READY);
      errors++;
    end
    if (DATA_OUT_I_ENABLE !== 1'b0) begin
      $display("ERROR %0t: DATA_OUT_I_ENABLE expected 0, got %0b", $time,
               DATA_OUT_I_ENABLE);
      errors++;
    end
    if (DATA_OUT_J_ENABLE !== 1'b0) begin
      $display("ERROR %0t: DATA_OUT_J_ENABLE expected 0, got %0b", $time,
               DATA_OUT_J_ENABLE);
      errors++;
    end
    if (DATA_OUT !== '0) begin
      $display("ERROR %0t: DATA_OUT expected 0, got %0d", $time, DATA_OUT);
      errors++;
    end
    tests_run++;
    if (errors == errors_before) begin
      $display("reset values: pass");
    end else begin
      tests_failed++;
      $display("reset values: FAIL");
    end

    m = '0;
    for (int i = 0; i < 4; i++) m[i][i] = DATA_SIZE'(1);
    run_request("identity 4x4", m, 4, 4, 65521, 0, 1'b0);
    m = '0;
    run_request("zero 3x3", m, 3, 3, 65521, 1, 1'b0);
    m = '0;
    m[2][1] = DATA_SIZE'(1234);
    run_request("single element 3x3", m, 3, 3, 65521, 1, 1'b0);

    for (int n = 0; n < 20; n++) begin
      random_matrix(m, 4, 4, 65521);
      run_request($sformatf("random 4x4 #%0d", n), m, 4, 4, 65521, 3, 1'b0);
    end

    // Odd shapes
    random_matrix(m, 2, 4, 65521);
    run_request("random 2x4", m, 2, 4, 65521, 2, 1'b0);
    random_matrix(m, 4, 3, 65521);
    m[3] = m[1];
    run_request("4x3 with repeated row", m, 4, 3, 65521, 2, 1'b0);
    m = '0;
    run_request("zero 1x1", m, 1, 1, 65521, 0, 1'b0);

    // Small prime makes products wrap often
    for (int n = 0; n < 12; n++) begin
      random_matrix(m, 4, 4, 7);
      run_request($sformatf("mod 7 4x4 #%0d", n), m, 4, 4, 7, 2, (n % 3) == 0);
    end

    $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: tb.f
rank_pkg.sv
mod_adder.sv
mod_multiplier.sv
matrix_rank.sv
tb_matrix_rank.sv

// File: run_sim.sh
#!/bin/sh
# Build the matrix rank testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f tb.f \
  --top-module tb_matrix_rank -o sim_tb_matrix_rank
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/sim_tb_matrix_rank)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "Finished with no errors"; then
  exit 0
fi
exit 1
